// ==== Bender.yml ====
package:
  name: rv_decode_stage

sources:
  - files:
      - hw/rv_decode_pkg.sv
      - hw/rv_pipe_reg.sv
      - hw/rv_regfile.sv
      - hw/rv_decoder.sv
      - hw/rv_decode_stage.sv

  - target: test
    files:
      - verif/rv_decode_stage_checker.sv
      - verif/rv_decode_stage_tb.sv

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = $clog2(NUM_REGS);

  ////////////////////////////////////////////////////////////////////////////
  // RV32IM encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_B       = 3'b000;  // Loads and stores
  localparam logic [2:0] F3_H       = 3'b001;
  localparam logic [2:0] F3_W       = 3'b010;
  localparam logic [2:0] F3_BU      = 3'b100;
  localparam logic [2:0] F3_HU      = 3'b101;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_BLTU    = 3'b110;
  localparam logic [2:0] F3_BGEU    = 3'b111;
  localparam logic [2:0] F3_JALR    = 3'b000;
  localparam logic [2:0] F3_PRIV    = 3'b000;  // ECALL, EBREAK, MRET
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;
  localparam logic [2:0] F3_MUL     = 3'b000;
  localparam logic [2:0] F3_MULH    = 3'b001;
  localparam logic [2:0] F3_MULHU   = 3'b011;
  localparam logic [2:0] F3_DIV     = 3'b100;
  localparam logic [2:0] F3_DIVU    = 3'b101;
  localparam logic [2:0] F3_REM     = 3'b110;
  localparam logic [2:0] F3_REMU    = 3'b111;

  localparam logic [6:0] F7_BASE    = 7'b000_0000;
  localparam logic [6:0] F7_ALT     = 7'b010_0000;  // SUB, SRA
  localparam logic [6:0] F7_MULDIV  = 7'b000_0001;

  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes and stage payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    INST_NOP, INST_RR, INST_RI, INST_LOAD, INST_STORE, INST_BRANCH,
    INST_JAL, INST_JALR, INST_LUI, INST_AUIPC, INST_CSRR
  } inst_type_e;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JUMP, ALU_LUI, ALU_AUIPC, ALU_CSRR,
    ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [3:0] {
    LSU_NOP, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
  } lsu_op_e;

  typedef enum logic [3:0] {
    BPU_NOP, BPU_BEQ, BPU_BNE, BPU_BLT, BPU_BGE, BPU_BLTU, BPU_BGEU,
    BPU_JAL, BPU_JALR
  } bpu_op_e;

  typedef enum logic [2:0] {
    CSR_NOP, CSR_CSRRW, CSR_CSRRS, CSR_ECALL, CSR_MRET
  } csr_op_e;

  typedef enum logic {
    WSEL_ALU, WSEL_LSU
  } wsel_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    inst_type_e        inst_type;
    alu_op_e           alu_op;
    lsu_op_e           lsu_op;
    bpu_op_e           bpu_op;
    csr_op_e           csr_op;
    wsel_e             wsel;
    logic              wena;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              illegal;
    logic              ebreak;
  } issue_t;

endpackage

// ==== hw/rv_decode_stage.sv ====
`timescale 1ns/100ps

module rv_decode_stage (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             fetch_valid_i,
  output logic                             fetch_ready_o,
  input  rv_decode_pkg::fetch_t            fetch_i,

  output logic                             issue_valid_o,
  input  logic                             issue_ready_i,
  output rv_decode_pkg::issue_t            issue_o,

  input  logic                             wb_en_i,
  input  logic [rv_decode_pkg::REG_AW-1:0] wb_addr_i,
  input  logic [rv_decode_pkg::XLEN-1:0]   wb_data_i
);

  import rv_decode_pkg::*;

  fetch_t            fetch_q;
  logic              fetch_q_valid;
  logic              issue_reg_ready;
  issue_t            issue_d;
  logic [REG_AW-1:0] raddr1;
  logic [REG_AW-1:0] raddr2;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch register, decode, issue register
  ////////////////////////////////////////////////////////////////////////////

  rv_pipe_reg #(
    .payload_t (fetch_t)
  ) u_fetch_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .data_i  (fetch_i),
    .valid_o (fetch_q_valid),
    .ready_i (issue_reg_ready),
    .data_o  (fetch_q)
  );

  rv_decoder u_decoder (
    .fetch_i  (fetch_q),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .issue_o  (issue_d)
  );

  rv_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_en_i),   // Writeback port
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i)
  );

  rv_pipe_reg #(
    .payload_t (issue_t)
  ) u_issue_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (fetch_q_valid),
    .ready_o (issue_reg_ready),
    .data_i  (issue_d),
    .valid_o (issue_valid_o),
    .ready_i (issue_ready_i),
    .data_o  (issue_o)
  );

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
  input  rv_decode_pkg::fetch_t            fetch_i,

  output logic [rv_decode_pkg::REG_AW-1:0] raddr1_o,
  output logic [rv_decode_pkg::REG_AW-1:0] raddr2_o,
  input  logic [rv_decode_pkg::XLEN-1:0]   rdata1_i,
  input  logic [rv_decode_pkg::XLEN-1:0]   rdata2_i,

  output rv_decode_pkg::issue_t            issue_o
);

  import rv_decode_pkg::*;

  wire [XLEN-1:0] inst    = fetch_i.inst;
  wire [11:0]     funct12 = inst[31:20];
  wire [6:0]      funct7  = inst[31:25];
  wire [4:0]      rs2     = inst[24:20];
  wire [4:0]      rs1     = inst[19:15];
  wire [2:0]      funct3  = inst[14:12];
  wire [4:0]      rd      = inst[11:7];
  wire [6:0]      opcode  = inst[6:0];

  wire [XLEN-1:0] imm_i = {{20{inst[31]}}, inst[31:20]};
  wire [XLEN-1:0] imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  wire [XLEN-1:0] imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  wire [XLEN-1:0] imm_u = {inst[31:12], 12'b0};
  wire [XLEN-1:0] imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  inst_type_e     inst_type;
  alu_op_e        alu_op;
  lsu_op_e        lsu_op;
  bpu_op_e        bpu_op;
  csr_op_e        csr_op;
  wsel_e          wsel;
  logic [XLEN-1:0] imm;
  logic           wena;
  logic           rena1;
  logic           rena2;
  logic           legal;
  logic           is_ebreak;

  ////////////////////////////////////////////////////////////////////////////
  // Per-opcode field decode, masked by legal below
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    inst_type = INST_NOP;
    alu_op    = ALU_NOP;
    lsu_op    = LSU_NOP;
    bpu_op    = BPU_NOP;
    csr_op    = CSR_NOP;
    wsel      = WSEL_ALU;
    imm       = '0;
    wena      = 1'b0;
    rena1     = 1'b0;
    rena2     = 1'b0;
    legal     = 1'b1;
    is_ebreak = 1'b0;
    case (opcode)
      OPC_OP: begin
        inst_type = INST_RR;
        {wena, rena1, rena2} = 3'b111;
        if (funct7 == F7_MULDIV) begin
          case (funct3)
            F3_MUL:   alu_op = ALU_MUL;
            F3_MULH:  alu_op = ALU_MULH;
            F3_MULHU: alu_op = ALU_MULHU;
            F3_DIV:   alu_op = ALU_DIV;
            F3_DIVU:  alu_op = ALU_DIVU;
            F3_REM:   alu_op = ALU_REM;
            F3_REMU:  alu_op = ALU_REMU;
            default:  legal  = 1'b0;  // MULHSU not supported
          endcase
        end else if (funct7 == F7_BASE ||
                     (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA))) begin
          case (funct3)
            F3_ADD_SUB: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
          endcase
        end else begin
          legal = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        inst_type = INST_RI;
        imm       = imm_i;
        {wena, rena1} = 2'b11;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          F3_SLL: begin
            alu_op = ALU_SLL;
            legal  = (funct7 == F7_BASE);
          end
          default: begin
            alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      OPC_LOAD: begin
        inst_type = INST_LOAD;
        imm       = imm_i;
        wsel      = WSEL_LSU;
        {wena, rena1} = 2'b11;
        case (funct3)
          F3_B:    lsu_op = LSU_LB;
          F3_H:    lsu_op = LSU_LH;
          F3_W:    lsu_op = LSU_LW;
          F3_BU:   lsu_op = LSU_LBU;
          F3_HU:   lsu_op = LSU_LHU;
          default: legal  = 1'b0;
        endcase
      end
      OPC_STORE: begin
        inst_type = INST_STORE;
        imm       = imm_s;
        {rena1, rena2} = 2'b11;
        case (funct3)
          F3_B:    lsu_op = LSU_SB;
          F3_H:    lsu_op = LSU_SH;
          F3_W:    lsu_op = LSU_SW;
          default: legal  = 1'b0;
        endcase
      end
      OPC_BRANCH: begin
        inst_type = INST_BRANCH;
        imm       = imm_b;
        {rena1, rena2} = 2'b11;
        case (funct3)
          F3_BEQ:  bpu_op = BPU_BEQ;
          F3_BNE:  bpu_op = BPU_BNE;
          F3_BLT:  bpu_op = BPU_BLT;
          F3_BGE:  bpu_op = BPU_BGE;
          F3_BLTU: bpu_op = BPU_BLTU;
          F3_BGEU: bpu_op = BPU_BGEU;
          default: legal  = 1'b0;
        endcase
      end
      OPC_JAL: begin
        inst_type = INST_JAL;
        imm       = imm_j;
        alu_op    = ALU_JUMP;  // Link address
        bpu_op    = BPU_JAL;
        wena      = 1'b1;
      end
      OPC_JALR: begin
        inst_type = INST_JALR;
        imm       = imm_i;
        alu_op    = ALU_JUMP;
        bpu_op    = BPU_JALR;
        {wena, rena1} = 2'b11;
        legal     = (funct3 == F3_JALR);
      end
      OPC_LUI: begin
        inst_type = INST_LUI;
        imm       = imm_u;
        alu_op    = ALU_LUI;
        wena      = 1'b1;
      end
      OPC_AUIPC: begin
        inst_type = INST_AUIPC;
        imm       = imm_u;
        alu_op    = ALU_AUIPC;
        wena      = 1'b1;
      end
      OPC_SYSTEM: begin
        inst_type = INST_CSRR;
        case (funct3)
          F3_CSRRW, F3_CSRRS: begin
            csr_op = (funct3 == F3_CSRRW) ? CSR_CSRRW : CSR_CSRRS;
            alu_op = ALU_CSRR;
            imm    = imm_i;  // CSR address
            {wena, rena1} = 2'b11;
          end
          F3_PRIV: begin
            if (funct12 == F12_ECALL) begin
              csr_op = CSR_ECALL;
            end else if (funct12 == F12_MRET) begin
              csr_op = CSR_MRET;
            end else begin
              is_ebreak = (funct12 == F12_EBREAK);
              legal     = is_ebreak;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Unused read ports fall back to x0
  assign raddr1_o = (legal && rena1) ? rs1 : '0;
  assign raddr2_o = (legal && rena2) ? rs2 : '0;

  assign issue_o.pc        = fetch_i.pc;
  assign issue_o.imm       = legal ? imm : '0;
  assign issue_o.inst_type = legal ? inst_type : INST_NOP;
  assign issue_o.alu_op    = legal ? alu_op : ALU_NOP;
  assign issue_o.lsu_op    = legal ? lsu_op : LSU_NOP;
  assign issue_o.bpu_op    = legal ? bpu_op : BPU_NOP;
  assign issue_o.csr_op    = legal ? csr_op : CSR_NOP;
  assign issue_o.wsel      = legal ? wsel : WSEL_ALU;
  assign issue_o.wena      = legal & wena;
  assign issue_o.waddr     = (legal && wena) ? rd : '0;
  assign issue_o.rs1_data  = rdata1_i;
  assign issue_o.rs2_data  = rdata2_i;
  assign issue_o.illegal   = ~legal;
  assign issue_o.ebreak    = is_ebreak;

endmodule

// ==== hw/rv_pipe_reg.sv ====
`timescale 1ns/100ps

module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,

  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;

  assign ready_o = ~full_q | ready_i;  // Empty slot or draining this cycle

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;  // Refill or go empty
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic [rv_decode_pkg::REG_AW-1:0] raddr1_i,
  input  logic [rv_decode_pkg::REG_AW-1:0] raddr2_i,
  output logic [rv_decode_pkg::XLEN-1:0]   rdata1_o,
  output logic [rv_decode_pkg::XLEN-1:0]   rdata2_o,

  input  logic                             we_i,
  input  logic [rv_decode_pkg::REG_AW-1:0] waddr_i,
  input  logic [rv_decode_pkg::XLEN-1:0]   wdata_i
);

  import rv_decode_pkg::*;

  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];  // No storage behind x0

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see writes from earlier edges only
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// ==== list.f ====
hw/rv_decode_pkg.sv
hw/rv_pipe_reg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_decode_stage.sv
verif/rv_decode_stage_checker.sv
verif/rv_decode_stage_tb.sv

// ==== verif/rv_decode_stage_checker.sv ====
`timescale 1ns/100ps

module rv_decode_stage_checker (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  issue_valid_i,
  input logic                  issue_ready_i,
  input rv_decode_pkg::issue_t issue_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Issue handshake
  ////////////////////////////////////////////////////////////////////////////

  a_issue_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_i))
    else $error("issue payload changed or dropped under back-pressure");

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !issue_valid_i)
    else $error("issue valid high in the first cycle after reset");

  ////////////////////////////////////////////////////////////////////////////
  // Decode invariants
  ////////////////////////////////////////////////////////////////////////////

  a_waddr_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !issue_i.wena |-> issue_i.waddr == '0)
    else $error("waddr nonzero without a register write");

  a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && issue_i.illegal |-> !issue_i.wena)
    else $error("illegal instruction requests a register write");

endmodule

bind rv_decode_stage rv_decode_stage_checker u_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .issue_valid_i (issue_valid_o),
  .issue_ready_i (issue_ready_i),
  .issue_i       (issue_o)
);

// ==== verif/rv_decode_stage_tb.sv ====
`timescale 1ns/100ps

module rv_decode_stage_tb;

  import rv_decode_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_INSTS  = 400;
  localparam int TIMEOUT_NS = (16 + 31 + NUM_INSTS * 8) * CLK_PERIOD;

  logic              clk_i;
  logic              rst_n_i;
  logic              fetch_valid_i;
  logic              fetch_ready_o;
  fetch_t            fetch_i;
  logic              issue_valid_o;
  logic              issue_ready_i;
  issue_t            issue_o;
  logic              wb_en_i;
  logic [REG_AW-1:0] wb_addr_i;
  logic [XLEN-1:0]   wb_data_i;

  int              seed = 56260;
  logic [XLEN-1:0] model_regs [NUM_REGS];
  issue_t          exp_q [$];
  int              n_gen;
  int              n_accepted;
  int              n_issued;
  logic            checking;
  logic            fetch_fire;
  logic            exp_f_full;  // Occupancy of the two stage registers
  logic            exp_i_full;
  logic            f_rdy;
  logic            i_rdy;
  logic [XLEN-1:0] pc_next;

  // Operation tables indexed by funct3, NOP marks an unused slot
  alu_op_e base_ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                            ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e md_ops [8]   = '{ALU_MUL, ALU_MULH, ALU_NOP, ALU_MULHU,
                            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  lsu_op_e load_ops [8] = '{LSU_LB, LSU_LH, LSU_LW, LSU_NOP,
                            LSU_LBU, LSU_LHU, LSU_NOP, LSU_NOP};
  lsu_op_e store_ops [8] = '{LSU_SB, LSU_SH, LSU_SW, LSU_NOP,
                             LSU_NOP, LSU_NOP, LSU_NOP, LSU_NOP};
  bpu_op_e br_ops [8]   = '{BPU_BEQ, BPU_BNE, BPU_NOP, BPU_NOP,
                            BPU_BLT, BPU_BGE, BPU_BLTU, BPU_BGEU};
  logic [6:0] opcodes [10] = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                               OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM};

  rv_decode_stage DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
    stop_run($sformatf("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) report_mismatch(name, exp, act);
  endtask

  task automatic compare_issue(input issue_t exp, input issue_t act);
    if (exp.pc !== act.pc) report_mismatch("issue_o.pc", exp.pc, act.pc);
    if (exp.imm !== act.imm) report_mismatch("issue_o.imm", exp.imm, act.imm);
    if (exp.inst_type !== act.inst_type)
      report_mismatch("issue_o.inst_type", exp.inst_type, act.inst_type);
    if (exp.alu_op !== act.alu_op) report_mismatch("issue_o.alu_op", exp.alu_op, act.alu_op);
    if (exp.lsu_op !== act.lsu_op) report_mismatch("issue_o.lsu_op", exp.lsu_op, act.lsu_op);
    if (exp.bpu_op !== act.bpu_op) report_mismatch("issue_o.bpu_op", exp.bpu_op, act.bpu_op);
    if (exp.csr_op !== act.csr_op) report_mismatch("issue_o.csr_op", exp.csr_op, act.csr_op);
    if (exp.wsel !== act.wsel) report_mismatch("issue_o.wsel", exp.wsel, act.wsel);
    if (exp.wena !== act.wena) report_mismatch("issue_o.wena", exp.wena, act.wena);
    if (exp.waddr !== act.waddr) report_mismatch("issue_o.waddr", exp.waddr, act.waddr);
    if (exp.rs1_data !== act.rs1_data)
      report_mismatch("issue_o.rs1_data", exp.rs1_data, act.rs1_data);
    if (exp.rs2_data !== act.rs2_data)
      report_mismatch("issue_o.rs2_data", exp.rs2_data, act.rs2_data);
    if (exp.illegal !== act.illegal) report_mismatch("issue_o.illegal", exp.illegal, act.illegal);
    if (exp.ebreak !== act.ebreak) report_mismatch("issue_o.ebreak", exp.ebreak, act.ebreak);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference decode and stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic issue_t model_decode(input fetch_t f);
    issue_t          e;
    logic [XLEN-1:0] w;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic            use1;
    logic            use2;
    logic            ok;
    w    = f.inst;
    f7   = w[31:25];
    f3   = w[14:12];
    e    = '0;
    use1 = 1'b0;
    use2 = 1'b0;
    ok   = 1'b1;
    case (w[6:0])
      OPC_OP: begin
        e.inst_type = INST_RR;
        e.wena      = 1'b1;
        use1        = 1'b1;
        use2        = 1'b1;
        if (f7 == F7_BASE) e.alu_op = base_ops[f3];
        else if (f7 == F7_MULDIV) e.alu_op = md_ops[f3];
        else if (f7 == F7_ALT && f3 == F3_ADD_SUB) e.alu_op = ALU_SUB;
        else if (f7 == F7_ALT && f3 == F3_SRL_SRA) e.alu_op = ALU_SRA;
        ok = (e.alu_op != ALU_NOP);
      end
      OPC_OP_IMM: begin
        e.inst_type = INST_RI;
        e.imm       = {{21{w[31]}}, w[30:20]};
        e.wena      = 1'b1;
        use1        = 1'b1;
        e.alu_op    = base_ops[f3];
        if (f3 == F3_SRL_SRA && f7 == F7_ALT) e.alu_op = ALU_SRA;
        else if ((f3 == F3_SLL || f3 == F3_SRL_SRA) && f7 != F7_BASE) e.alu_op = ALU_NOP;
        ok = (e.alu_op != ALU_NOP);
      end
      OPC_LOAD: begin
        e.inst_type = INST_LOAD;
        e.imm       = {{21{w[31]}}, w[30:20]};
        e.wsel      = WSEL_LSU;
        e.wena      = 1'b1;
        use1        = 1'b1;
        e.lsu_op    = load_ops[f3];
        ok          = (e.lsu_op != LSU_NOP);
      end
      OPC_STORE: begin
        e.inst_type = INST_STORE;
        e.imm       = {{21{w[31]}}, w[30:25], w[11:7]};
        use1        = 1'b1;
        use2        = 1'b1;
        e.lsu_op    = store_ops[f3];
        ok          = (e.lsu_op != LSU_NOP);
      end
      OPC_BRANCH: begin
        e.inst_type = INST_BRANCH;
        e.imm       = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        use1        = 1'b1;
        use2        = 1'b1;
        e.bpu_op    = br_ops[f3];
        ok          = (e.bpu_op != BPU_NOP);
      end
      OPC_JAL: begin
        e.inst_type = INST_JAL;
        e.imm       = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e.alu_op    = ALU_JUMP;
        e.bpu_op    = BPU_JAL;
        e.wena      = 1'b1;
      end
      OPC_JALR: begin
        e.inst_type = INST_JALR;
        e.imm       = {{21{w[31]}}, w[30:20]};
        e.alu_op    = ALU_JUMP;
        e.bpu_op    = BPU_JALR;
        e.wena      = 1'b1;
        use1        = 1'b1;
        ok          = (f3 == F3_JALR);
      end
      OPC_LUI, OPC_AUIPC: begin
        e.inst_type = (w[5]) ? INST_LUI : INST_AUIPC;
        e.alu_op    = (w[5]) ? ALU_LUI : ALU_AUIPC;
        e.imm       = {w[31:12], 12'h000};
        e.wena      = 1'b1;
      end
      OPC_SYSTEM: begin
        e.inst_type = INST_CSRR;
        if (f3 == F3_CSRRW || f3 == F3_CSRRS) begin
          e.csr_op = (f3 == F3_CSRRW) ? CSR_CSRRW : CSR_CSRRS;
          e.alu_op = ALU_CSRR;
          e.imm    = {{21{w[31]}}, w[30:20]};
          e.wena   = 1'b1;
          use1     = 1'b1;
        end else if (f3 != F3_PRIV) ok = 1'b0;
        else if (w[31:20] == F12_ECALL) e.csr_op = CSR_ECALL;
        else if (w[31:20] == F12_MRET) e.csr_op = CSR_MRET;
        else if (w[31:20] == F12_EBREAK) e.ebreak = 1'b1;
        else ok = 1'b0;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      e         = '0;
      e.illegal = 1'b1;
      use1      = 1'b0;
      use2      = 1'b0;
    end
    e.pc       = f.pc;
    e.waddr    = e.wena ? w[11:7] : '0;
    e.rs1_data = use1 ? model_regs[w[19:15]] : '0;  // x0 stays zero in the model
    e.rs2_data = use2 ? model_regs[w[24:20]] : '0;
    return e;
  endfunction

  function automatic logic [XLEN-1:0] gen_inst();
    logic [XLEN-1:0] w;
    w = $random(seed);
    if (($random(seed) & 7) == 0) return w;  // Fully random word
    w[6:0] = opcodes[$unsigned($random(seed)) % 10];
    case (w[6:0])
      OPC_OP: begin
        case (w[26:25])
          2'b00: w[31:25] = F7_MULDIV;
          2'b01: begin
            w[31:25] = F7_ALT;
            w[14:12] = {w[14], 1'b0, w[14]};  // SUB or SRA
          end
          default: w[31:25] = F7_BASE;
        endcase
      end
      OPC_OP_IMM: begin
        if (w[14:12] == F3_SLL) w[31:25] = F7_BASE;
        else if (w[14:12] == F3_SRL_SRA) w[31:25] = w[30] ? F7_ALT : F7_BASE;
      end
      OPC_LOAD: if (w[13] && (w[12] || w[14])) w[14:12] = F3_W;
      OPC_STORE: begin
        w[14] = 1'b0;
        if (w[13:12] == 2'b11) w[14:12] = F3_W;
      end
      OPC_BRANCH: if (!w[14]) w[13] = 1'b0;
      OPC_JALR: w[14:12] = F3_JALR;
      OPC_SYSTEM: begin
        w[14:12] = {1'b0, w[13] & ~w[12], w[12] & ~w[13]};
        if (w[14:12] == F3_PRIV) begin
          case (w[22:21])
            2'b00: w[31:20] = F12_ECALL;
            2'b01: w[31:20] = F12_EBREAK;
            2'b10: w[31:20] = F12_MRET;
            default: w[31:20] = w[31:20];  // Random funct12
          endcase
        end
      end
      default: w = w;
    endcase
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshake model and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (checking) begin
      i_rdy = !exp_i_full || issue_ready_i;
      f_rdy = !exp_f_full || i_rdy;
      compare_bit("fetch_ready_o", f_rdy, fetch_ready_o);
      compare_bit("issue_valid_o", exp_i_full, issue_valid_o);
      if (issue_valid_o && issue_ready_i) begin
        if (exp_q.size() == 0) stop_run("Issue transfer without an accepted word");
        compare_issue(exp_q.pop_front(), issue_o);
        n_issued++;
      end
      fetch_fire = fetch_valid_i && fetch_ready_o;
      if (fetch_fire) begin
        exp_q.push_back(model_decode(fetch_i));
        n_accepted++;
      end
      exp_i_full = i_rdy ? exp_f_full : exp_i_full;
      exp_f_full = f_rdy ? fetch_valid_i : exp_f_full;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    stop_run("Timeout: the decode stage stopped making progress");
  end

  initial begin
    rst_n_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_i       = '0;
    issue_ready_i = 1'b0;
    wb_en_i       = 1'b0;
    wb_addr_i     = '0;
    wb_data_i     = '0;
    checking      = 1'b0;
    fetch_fire    = 1'b0;
    exp_f_full    = 1'b0;
    exp_i_full    = 1'b0;
    n_gen         = 0;
    n_accepted    = 0;
    n_issued      = 0;
    pc_next       = 32'h0000_1000;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(negedge clk_i);
    rst_n_i  = 1'b1;
    checking = 1'b1;
    @(negedge clk_i);
    compare_bit("fetch_ready_o", 1'b1, fetch_ready_o);
    compare_bit("issue_valid_o", 1'b0, issue_valid_o);

    // Preload x1..x31, then try x0 last
    for (int i = 1; i <= NUM_REGS; i++) begin
      wb_en_i   = 1'b1;
      wb_addr_i = REG_AW'(i % NUM_REGS);
      wb_data_i = $random(seed);
      if (wb_addr_i != '0) model_regs[wb_addr_i] = wb_data_i;
      @(negedge clk_i);
    end
    wb_en_i = 1'b0;

    while (n_accepted < NUM_INSTS) begin
      @(negedge clk_i);
      if (!fetch_valid_i || fetch_fire) begin  // Producer holds until taken
        if (n_gen < NUM_INSTS && ($random(seed) & 3) != 0) begin
          fetch_i.pc    = pc_next;
          fetch_i.inst  = gen_inst();
          fetch_valid_i = 1'b1;
          pc_next       = pc_next + 4;
          n_gen++;
        end else begin
          fetch_valid_i = 1'b0;
        end
      end
      issue_ready_i = ($random(seed) & 3) != 0;
    end

    while (n_issued < n_accepted) begin
      @(negedge clk_i);
      issue_ready_i = ($random(seed) & 3) != 0;
    end
    @(negedge clk_i);

    if (n_accepted == NUM_INSTS && n_issued == NUM_INSTS && exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_run($sformatf("Issued %0d words for %0d accepted", n_issued, n_accepted));
    end
  end

endmodule
